// File: Makefile
# Verilator build and run for the AXI write master testbench

VERILATOR ?= verilator
TOP       ?= axi_writer_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
+incdir+src
src/axw_pkg.sv
src/addr_cmd_if.sv
src/addr_range_wrap.sv
src/burst_splitter.sv
src/wlast_gen.sv
src/axi_writer_core.sv
verif/axi_writer_chk.sv
verif/axi_writer_tb.sv

// File: src/addr_cmd_if.sv
// ----------------------------------------------------------------------
// Address command stream
// start address and length with a valid/ready handshake
// ----------------------------------------------------------------------

`default_nettype none

interface addr_cmd_if #(
    parameter type len_t = axw_pkg::s_len_t
);
    import axw_pkg::*;

    addr_t  addr;
    len_t   len;
    logic   valid;
    logic   ready;

    modport src (output addr, output len, output valid, input ready);

    modport dst (input addr, input len, input valid, output ready);

endinterface

`default_nettype wire

// File: src/addr_range_wrap.sv
// ----------------------------------------------------------------------
// Address window wrap
// cuts a command at the window end and continues it at the window start
// ----------------------------------------------------------------------

`default_nettype none

`include "axw_defines.svh"

module addr_range_wrap (
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire axw_pkg::addr_t     range_start,
    input  wire axw_pkg::addr_t     range_end,
    input  wire axw_pkg::addr_t     s_awaddr,
    input  wire axw_pkg::s_len_t    s_awlen,
    input  wire                     s_awvalid,
    output logic                    s_awready,
    addr_cmd_if.src                 m,
    output logic                    busy
);
    import axw_pkg::*;

    logic       armed;
    logic       hold;
    addr_t      cur_addr;
    s_len_t     rem_m1;
    addr_t      seg_beats;
    logic       seg_last;
    logic       emit;

    // beats that still fit before the window end
    assign seg_beats = (range_end - cur_addr) >> `AXW_DATA_SIZE;
    assign seg_last  = addr_t'(rem_m1) < seg_beats;
    assign emit      = hold && (!m.valid || m.ready);

    assign s_awready = armed && !hold;
    assign busy      = hold || m.valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            armed   <= 1'b0;
            hold    <= 1'b0;
            m.valid <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (s_awvalid && s_awready) begin
                hold <= 1'b1;
            end else if (emit && seg_last) begin
                hold <= 1'b0;
            end
            if (emit) begin
                m.valid <= 1'b1;
            end else if (m.ready) begin
                m.valid <= 1'b0;
            end
        end
    end

    // remainder restarts at range_start
    always_ff @(posedge aclk) begin
        if (s_awvalid && s_awready) begin
            cur_addr <= s_awaddr;
            rem_m1   <= s_awlen;
        end else if (emit && !seg_last) begin
            cur_addr <= range_start;
            rem_m1   <= rem_m1 - s_len_t'(seg_beats);
        end
        if (emit) begin
            m.addr <= cur_addr;
            m.len  <= seg_last ? rem_m1 : s_len_t'(seg_beats - 1'b1);
        end
    end

endmodule

`default_nettype wire

// File: src/axi_writer_core.sv
// ----------------------------------------------------------------------
// AXI4 write master
// turns linear write commands and a data stream into AXI4 write bursts
// ----------------------------------------------------------------------

`default_nettype none

`include "axw_defines.svh"

module axi_writer_core (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire axw_pkg::addr_t         range_start,
    input  wire axw_pkg::addr_t         range_end,
    input  wire axw_pkg::burst_len_t    maxlen,
    input  wire axw_pkg::addr_t         s_awaddr,
    input  wire axw_pkg::s_len_t        s_awlen,
    input  wire                         s_awvalid,
    output logic                        s_awready,
    input  wire axw_pkg::data_t         s_tdata,
    input  wire axw_pkg::strb_t         s_tstrb,
    input  wire                         s_tvalid,
    output logic                        s_tready,
    output axw_pkg::addr_t              m_axi_awaddr,
    output axw_pkg::burst_len_t         m_axi_awlen,
    output logic                        m_axi_awvalid,
    input  wire                         m_axi_awready,
    output axw_pkg::data_t              m_axi_wdata,
    output axw_pkg::strb_t              m_axi_wstrb,
    output logic                        m_axi_wlast,
    output logic                        m_axi_wvalid,
    input  wire                         m_axi_wready,
    input  wire [1:0]                   m_axi_bresp,
    input  wire                         m_axi_bvalid,
    output logic                        m_axi_bready,
    output logic                        busy
);
    import axw_pkg::*;

    addr_cmd_if #(.len_t(s_len_t))      wrapped ();
    addr_cmd_if #(.len_t(burst_len_t))  bursts ();

    logic                               range_busy;
    logic                               split_busy;
    logic                               last_busy;
    logic                               len_valid;
    logic                               len_ready;
    logic                               aw_taken;
    logic                               len_taken;
    logic                               aw_done;
    logic                               len_done;
    logic                               b_hs;
    logic [`AXW_OUTSTANDING_WIDTH-1:0]  outstanding;
    logic                               idle;

    // ------------------------------------------------------------------
    // command path
    // ------------------------------------------------------------------

    addr_range_wrap u_addr_range_wrap (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .range_start (range_start),
        .range_end   (range_end),
        .s_awaddr    (s_awaddr),
        .s_awlen     (s_awlen),
        .s_awvalid   (s_awvalid),
        .s_awready   (s_awready),
        .m           (wrapped),
        .busy        (range_busy)
    );

    burst_splitter u_burst_splitter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .maxlen  (maxlen),
        .s       (wrapped),
        .m       (bursts),
        .busy    (split_busy)
    );

    // ------------------------------------------------------------------
    // fork to AW and to the length FIFO
    // ------------------------------------------------------------------

    // AW waits for FIFO room unless the length is already queued
    assign m_axi_awaddr  = bursts.addr;
    assign m_axi_awlen   = bursts.len;
    assign m_axi_awvalid = bursts.valid && !aw_taken && (len_taken || len_ready);
    assign len_valid     = bursts.valid && !len_taken;

    assign aw_done      = aw_taken || (m_axi_awvalid && m_axi_awready);
    assign len_done     = len_taken || (len_valid && len_ready);
    assign bursts.ready = aw_done && len_done;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            aw_taken  <= 1'b0;
            len_taken <= 1'b0;
        end else if (bursts.valid && bursts.ready) begin
            aw_taken  <= 1'b0;
            len_taken <= 1'b0;
        end else begin
            aw_taken  <= aw_done;
            len_taken <= len_done;
        end
    end

    // ------------------------------------------------------------------
    // data path
    // ------------------------------------------------------------------

    wlast_gen u_wlast_gen (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .len_data  (bursts.len),
        .len_valid (len_valid),
        .len_ready (len_ready),
        .s_tdata   (s_tdata),
        .s_tstrb   (s_tstrb),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .m_wdata   (m_axi_wdata),
        .m_wstrb   (m_axi_wstrb),
        .m_wlast   (m_axi_wlast),
        .m_wvalid  (m_axi_wvalid),
        .m_wready  (m_axi_wready),
        .busy      (last_busy)
    );

    // ------------------------------------------------------------------
    // responses and busy
    // ------------------------------------------------------------------

    // every response is taken, bresp is not decoded
    assign m_axi_bready = 1'b1;
    assign b_hs         = m_axi_bvalid && m_axi_bready;

    assign idle = !range_busy && !split_busy && !aw_taken && !len_taken
               && !last_busy && (outstanding == '0);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            outstanding <= '0;
            busy        <= 1'b0;
        end else begin
            outstanding <= outstanding
                         + `AXW_OUTSTANDING_WIDTH'(m_axi_awvalid && m_axi_awready)
                         - `AXW_OUTSTANDING_WIDTH'(b_hs);
            if (s_awvalid && s_awready) begin
                busy <= 1'b1;
            end else if (idle) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/axw_defines.svh
// ----------------------------------------------------------------------
// AXI write master configuration
// bus widths, burst alignment and burst-length FIFO sizing
// ----------------------------------------------------------------------

`ifndef AXW_DEFINES_SVH
`define AXW_DEFINES_SVH

// byte address width
`define AXW_ADDR_WIDTH          32

// log2 of bytes per beat, 2 gives a 32-bit beat
`define AXW_DATA_SIZE           2

// input command length, beats minus one
`define AXW_S_LEN_WIDTH         16

// AXI awlen width
`define AXW_BURST_LEN_WIDTH     8

// no burst may cross a 2**ALIGN byte boundary
`define AXW_ALIGN               12

// burst-length FIFO depth, log2
`define AXW_LEN_FIFO_LOG2       4

// bursts issued and still waiting for B
`define AXW_OUTSTANDING_WIDTH   8

`endif

// File: src/axw_pkg.sv
// ----------------------------------------------------------------------
// AXI write master types
// address, length, data and strobe types shared by all stages
// ----------------------------------------------------------------------

`default_nettype none

`include "axw_defines.svh"

package axw_pkg;

    // byte address
    typedef logic [`AXW_ADDR_WIDTH-1:0]         addr_t;

    // beats minus one, command side and burst side
    typedef logic [`AXW_S_LEN_WIDTH-1:0]        s_len_t;
    typedef logic [`AXW_BURST_LEN_WIDTH-1:0]    burst_len_t;

    // one beat and its byte enables
    typedef logic [(8 << `AXW_DATA_SIZE)-1:0]   data_t;
    typedef logic [(1 << `AXW_DATA_SIZE)-1:0]   strb_t;

endpackage

`default_nettype wire

// File: src/burst_splitter.sv
// ----------------------------------------------------------------------
// Burst splitter
// cuts commands into bursts of at most maxlen+1 beats that never
// cross a 4 KiB boundary
// ----------------------------------------------------------------------

`default_nettype none

`include "axw_defines.svh"

module burst_splitter (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire axw_pkg::burst_len_t    maxlen,
    addr_cmd_if.dst                     s,
    addr_cmd_if.src                     m,
    output logic                        busy
);
    import axw_pkg::*;

    // beat index width inside one aligned block
    localparam int BLK_W = `AXW_ALIGN - `AXW_DATA_SIZE;

    logic               hold;
    addr_t              cur_addr;
    s_len_t             rem_m1;
    logic [BLK_W-1:0]   to_bound_m1;
    s_len_t             cap_m1;
    s_len_t             step;
    logic               last;
    logic               emit;

    // ------------------------------------------------------------------
    // burst size
    // ------------------------------------------------------------------

    // beats to the next boundary, minus one
    assign to_bound_m1 = ~cur_addr[`AXW_ALIGN-1:`AXW_DATA_SIZE];

    assign cap_m1 = (s_len_t'(to_bound_m1) < s_len_t'(maxlen))
                  ? s_len_t'(to_bound_m1)
                  : s_len_t'(maxlen);

    assign step = cap_m1 + 1'b1;
    assign last = rem_m1 <= cap_m1;
    assign emit = hold && (!m.valid || m.ready);

    assign s.ready = !hold;
    assign busy    = hold || m.valid;

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hold    <= 1'b0;
            m.valid <= 1'b0;
        end else begin
            if (s.valid && s.ready) begin
                hold <= 1'b1;
            end else if (emit && last) begin
                hold <= 1'b0;
            end
            if (emit) begin
                m.valid <= 1'b1;
            end else if (m.ready) begin
                m.valid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // address and length
    // ------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (s.valid && s.ready) begin
            cur_addr <= s.addr;
            rem_m1   <= s.len;
        end else if (emit && !last) begin
            cur_addr <= cur_addr + (addr_t'(step) << `AXW_DATA_SIZE);
            rem_m1   <= rem_m1 - step;
        end
        if (emit) begin
            m.addr <= cur_addr;
            m.len  <= burst_len_t'(last ? rem_m1 : cap_m1);
        end
    end

endmodule

`default_nettype wire

// File: src/wlast_gen.sv
// ----------------------------------------------------------------------
// wlast generator
// queues burst lengths and marks the last data beat of each burst
// ----------------------------------------------------------------------

`default_nettype none

`include "axw_defines.svh"

module wlast_gen (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire axw_pkg::burst_len_t    len_data,
    input  wire                         len_valid,
    output logic                        len_ready,
    input  wire axw_pkg::data_t         s_tdata,
    input  wire axw_pkg::strb_t         s_tstrb,
    input  wire                         s_tvalid,
    output logic                        s_tready,
    output axw_pkg::data_t              m_wdata,
    output axw_pkg::strb_t              m_wstrb,
    output logic                        m_wlast,
    output logic                        m_wvalid,
    input  wire                         m_wready,
    output logic                        busy
);
    import axw_pkg::*;

    localparam int DEPTH = 1 << `AXW_LEN_FIFO_LOG2;

    burst_len_t                     mem [DEPTH];
    logic [`AXW_LEN_FIFO_LOG2:0]    wr_ptr;
    logic [`AXW_LEN_FIFO_LOG2:0]    rd_ptr;
    logic [`AXW_LEN_FIFO_LOG2:0]    fill;
    logic                           empty;
    logic                           push;
    logic                           pop;
    logic                           active;
    burst_len_t                     beat_cnt;
    logic                           take;
    logic                           last_take;

    // fill never exceeds DEPTH, so its top bit means full
    assign fill      = wr_ptr - rd_ptr;
    assign empty     = fill == '0;
    assign len_ready = !fill[`AXW_LEN_FIFO_LOG2];
    assign push      = len_valid && len_ready;

    assign s_tready  = active && (!m_wvalid || m_wready);
    assign take      = s_tvalid && s_tready;
    assign last_take = take && (beat_cnt == '0);
    // next length loads on the last beat, no gap between bursts
    assign pop       = !empty && (!active || last_take);

    assign busy = !empty || active || m_wvalid;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr[`AXW_LEN_FIFO_LOG2-1:0]] <= len_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            active   <= 1'b0;
            beat_cnt <= '0;
            m_wvalid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr   <= rd_ptr + 1'b1;
                beat_cnt <= mem[rd_ptr[`AXW_LEN_FIFO_LOG2-1:0]];
                active   <= 1'b1;
            end else if (last_take) begin
                active <= 1'b0;
            end else if (take) begin
                beat_cnt <= beat_cnt - 1'b1;
            end
            if (take) begin
                m_wvalid <= 1'b1;
            end else if (m_wready) begin
                m_wvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            m_wdata <= s_tdata;
            m_wstrb <= s_tstrb;
            m_wlast <= beat_cnt == '0;
        end
    end

endmodule

`default_nettype wire

// File: verif/axi_writer_chk.sv
// ----------------------------------------------------------------------
// AXI write master protocol checks
// AW and W stability under back-pressure, busy after reset
// ----------------------------------------------------------------------

`default_nettype none

module axi_writer_chk (
    input wire                          aclk,
    input wire                          aresetn,
    input wire axw_pkg::addr_t          m_axi_awaddr,
    input wire axw_pkg::burst_len_t     m_axi_awlen,
    input wire                          m_axi_awvalid,
    input wire                          m_axi_awready,
    input wire axw_pkg::data_t          m_axi_wdata,
    input wire axw_pkg::strb_t          m_axi_wstrb,
    input wire                          m_axi_wlast,
    input wire                          m_axi_wvalid,
    input wire                          m_axi_wready,
    input wire                          busy
);
    timeunit 1ns;
    timeprecision 1ps;

    property aw_stall_hold;
        @(posedge aclk) disable iff (!aresetn)
            m_axi_awvalid && !m_axi_awready
            |=> m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen);
    endproperty

    property w_stall_hold;
        @(posedge aclk) disable iff (!aresetn)
            m_axi_wvalid && !m_axi_wready
            |=> m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb)
                && $stable(m_axi_wlast);
    endproperty

    aw_hold_a: assert property (aw_stall_hold)
        else $error("AW dropped or changed while stalled");

    w_hold_a: assert property (w_stall_hold)
        else $error("W dropped or changed while stalled");

    // nothing accepted yet, so busy stays low
    busy_reset_a: assert property (@(posedge aclk) $rose(aresetn) |=> !busy)
        else $error("busy high right after reset");

endmodule

bind axi_writer_core axi_writer_chk u_axi_writer_chk (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awlen   (m_axi_awlen),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .busy          (busy)
);

`default_nettype wire

// File: verif/axi_writer_tb.sv
// ----------------------------------------------------------------------
// AXI write master testbench
// command table, reference burst model, AXI slave model and checks
// ----------------------------------------------------------------------

`default_nettype none

module axi_writer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import axw_pkg::*;

    localparam int TIMEOUT = 2000;
    localparam int NROWS   = 6;

    typedef struct {
        addr_t  addr;
        int     len;
        addr_t  range_start;
        addr_t  range_end;
        int     maxlen;
    } row_t;

    logic aclk;
    logic aresetn;
    addr_t range_start;
    addr_t range_end;
    burst_len_t maxlen;
    addr_t s_awaddr;
    s_len_t s_awlen;
    logic s_awvalid;
    logic s_awready;
    data_t s_tdata;
    strb_t s_tstrb;
    logic s_tvalid;
    logic s_tready;
    addr_t m_axi_awaddr;
    burst_len_t m_axi_awlen;
    logic m_axi_awvalid;
    logic m_axi_awready;
    data_t m_axi_wdata;
    strb_t m_axi_wstrb;
    logic m_axi_wlast;
    logic m_axi_wvalid;
    logic m_axi_wready;
    logic [1:0] m_axi_bresp;
    logic m_axi_bvalid;
    logic m_axi_bready;
    logic busy;

    row_t rows [NROWS];
    logic [31:0] seed;
    addr_t exp_addr_q [$];
    int exp_len_q [$];
    int data_base;
    int aw_seen;
    int w_bursts_seen;
    int b_sent;

    axi_writer_core u_axi_writer_core (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = lcg_next();
        return int'((r >> 16) % 100) < pct;
    endfunction

    function automatic data_t beat_data(input int idx);
        return 32'hc0de_0000 + data_t'(idx);
    endfunction

    function automatic strb_t beat_strb(input int idx);
        return ~(strb_t'(1) << (idx % 4));
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    // ------------------------------------------------------------------
    // reference model, window wrap then maxlen and 4 KiB cuts
    // ------------------------------------------------------------------

    task automatic build_expected(input row_t r);
        longint a;
        longint p;
        int left;
        int seg;
        int p_left;
        int cut;
        int to_bound;
        exp_addr_q.delete();
        exp_len_q.delete();
        a = r.addr;
        left = r.len + 1;
        while (left > 0) begin
            seg = int'((longint'(r.range_end) - a) / 4);
            if (seg > left) seg = left;
            p = a;
            p_left = seg;
            while (p_left > 0) begin
                to_bound = int'((4096 - (p % 4096)) / 4);
                cut = p_left;
                if (cut > r.maxlen + 1) cut = r.maxlen + 1;
                if (cut > to_bound) cut = to_bound;
                exp_addr_q.push_back(addr_t'(p));
                exp_len_q.push_back(cut - 1);
                p += cut * 4;
                p_left -= cut;
            end
            left -= seg;
            a = r.range_start;
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge aclk);
        while (busy) begin
            waited++;
            if (waited > TIMEOUT) give_up("busy to fall");
            @(negedge aclk);
        end
    endtask

    task automatic send_cmd(input row_t r);
        int waited;
        waited = 0;
        @(posedge aclk);
        #1;
        range_start = r.range_start;
        range_end   = r.range_end;
        maxlen      = burst_len_t'(r.maxlen);
        s_awaddr    = r.addr;
        s_awlen     = s_len_t'(r.len);
        s_awvalid   = 1'b1;
        @(negedge aclk);
        while (!s_awready) begin
            waited++;
            if (waited > TIMEOUT) give_up("s_awready");
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        s_awvalid = 1'b0;
        @(negedge aclk);
        check("busy", busy, 1);
    endtask

    // ------------------------------------------------------------------
    // stream source and AXI slave model
    // ------------------------------------------------------------------

    task automatic feed_data(input int nbeats);
        int sent;
        int idle;
        logic fire;
        sent = 0;
        idle = 0;
        fire = 1'b0;
        while (sent < nbeats) begin
            @(posedge aclk);
            #1;
            if (fire) sent++;
            if (sent == nbeats) begin
                s_tvalid = 1'b0;
            end else if (!s_tvalid || fire) begin
                s_tvalid = chance(75);
                s_tdata  = beat_data(data_base + sent);
                s_tstrb  = beat_strb(data_base + sent);
            end
            @(negedge aclk);
            fire = s_tvalid && s_tready;
            idle = fire ? 0 : idle + 1;
            if (idle > TIMEOUT) give_up("s_tready");
        end
    endtask

    task automatic aw_slave(input int nbursts);
        int idle;
        idle = 0;
        while (aw_seen < nbursts) begin
            @(posedge aclk);
            #1;
            m_axi_awready = chance(60);
            @(negedge aclk);
            if (m_axi_awvalid && m_axi_awready) begin
                check("m_axi_awaddr", m_axi_awaddr, exp_addr_q[aw_seen]);
                check("m_axi_awlen", m_axi_awlen, exp_len_q[aw_seen]);
                aw_seen++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) give_up("an AW handshake");
            end
        end
        @(posedge aclk);
        #1;
        m_axi_awready = 1'b0;
    endtask

    task automatic w_slave(input int nbeats);
        int got;
        int beat;
        int idle;
        got = 0;
        beat = 0;
        idle = 0;
        while (got < nbeats) begin
            @(posedge aclk);
            #1;
            m_axi_wready = chance(70);
            @(negedge aclk);
            if (m_axi_wvalid && m_axi_wready) begin
                check("m_axi_wdata", m_axi_wdata, beat_data(data_base + got));
                check("m_axi_wstrb", m_axi_wstrb, beat_strb(data_base + got));
                check("m_axi_wlast", m_axi_wlast, beat == exp_len_q[w_bursts_seen]);
                beat = m_axi_wlast ? 0 : beat + 1;
                if (m_axi_wlast) w_bursts_seen++;
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) give_up("a W handshake");
            end
        end
        @(posedge aclk);
        #1;
        m_axi_wready = 1'b0;
    endtask

    // one B per burst, only once both its AW and its last beat are done
    task automatic b_slave(input int nbursts);
        int idle;
        int owed;
        logic fire;
        idle = 0;
        fire = 1'b0;
        while (b_sent < nbursts) begin
            @(posedge aclk);
            #1;
            owed = (aw_seen < w_bursts_seen) ? aw_seen : w_bursts_seen;
            if (!m_axi_bvalid || fire) m_axi_bvalid = (b_sent < owed) && chance(60);
            @(negedge aclk);
            check("busy", busy, 1);
            check("m_axi_bready", m_axi_bready, 1);
            fire = m_axi_bvalid && m_axi_bready;
            if (fire) b_sent++;
            idle = fire ? 0 : idle + 1;
            if (idle > TIMEOUT) give_up("a B handshake");
        end
        @(posedge aclk);
        #1;
        m_axi_bvalid = 1'b0;
    endtask

    initial begin
        int nbeats;
        seed = 32'h1b02;
        data_base = 0;
        aresetn = 1'b0;
        range_start = '0;
        range_end = '0;
        maxlen = '0;
        s_awaddr = '0;
        s_awlen = '0;
        s_awvalid = 1'b0;
        s_tdata = '0;
        s_tstrb = '0;
        s_tvalid = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready = 1'b0;
        m_axi_bresp = 2'b00;
        m_axi_bvalid = 1'b0;
        // addr, len, range_start, range_end, maxlen
        rows[0] = '{32'h1000_0100, 7, 32'h1000_0000, 32'h1001_0000, 255};
        rows[1] = '{32'h1000_0200, 39, 32'h1000_0000, 32'h1001_0000, 15};
        rows[2] = '{32'h1000_0ff0, 11, 32'h1000_0000, 32'h1001_0000, 255};
        rows[3] = '{32'h2000_1fe0, 29, 32'h2000_0ff8, 32'h2000_2000, 7};
        rows[4] = '{32'h3000_0f00, 299, 32'h3000_0e00, 32'h3000_1100, 63};
        rows[5] = '{32'h4000_0000, 255, 32'h4000_0000, 32'h4001_0000, 0};
        repeat (8) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(negedge aclk);
        check("busy", busy, 0);
        for (int i = 0; i < NROWS; i++) begin
            wait_idle();
            build_expected(rows[i]);
            aw_seen = 0;
            w_bursts_seen = 0;
            b_sent = 0;
            nbeats = rows[i].len + 1;
            send_cmd(rows[i]);
            fork
                feed_data(nbeats);
                aw_slave(exp_addr_q.size());
                w_slave(nbeats);
                b_slave(exp_addr_q.size());
            join
            wait_idle();
            check("m_axi_awvalid", m_axi_awvalid, 0);
            data_base += nbeats;
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
